/* Bender.yml */
package:
  name: ex_pipe

sources:
  - logic/ex_pkg.sv
  - logic/ex_alu.sv
  - logic/ex_bru.sv
  - logic/ex_agu.sv
  - logic/ex_stage_buf.sv
  - logic/ex_pipe.sv
  - target: test
    files:
      - tb/tb_ex_pipe.sv

/* all.f */
logic/ex_pkg.sv
logic/ex_alu.sv
logic/ex_bru.sv
logic/ex_agu.sv
logic/ex_stage_buf.sv
logic/ex_pipe.sv
tb/tb_ex_pipe.sv

/* logic/ex_agu.sv */
// Address output and alignment check for load/store/system ops
module ex_agu (
   input  ex_pkg::mem_sz_e           mem_sz,
   input  logic [ex_pkg::XLEN-1:0]   sum,
   output logic [ex_pkg::XLEN-1:0]   addr,
   output logic                      misalign
);

   // Address is op1 + imm from the shared adder
   assign addr = sum;

   always_comb begin
      case (mem_sz)
         ex_pkg::MEM_H: begin
            misalign = sum[0];
         end
         ex_pkg::MEM_W: begin
            misalign = |sum[1:0];
         end
         default: begin
            // Byte accesses are always aligned
            misalign = 1'b0;
         end
      endcase
   end

endmodule

/* logic/ex_alu.sv */
// ALU result select for add/sub, bitwise logic and shifts
module ex_alu (
   input  ex_pkg::alu_op_e           alu_op,
   input  logic [ex_pkg::XLEN-1:0]   op1,
   input  logic [ex_pkg::XLEN-1:0]   op2,
   input  logic [ex_pkg::XLEN-1:0]   sum,
   output logic [ex_pkg::XLEN-1:0]   result
);

   logic [4:0]              shamt;
   logic [ex_pkg::XLEN-1:0] shl;
   logic [ex_pkg::XLEN-1:0] shr_l;
   logic [ex_pkg::XLEN-1:0] shr_a;

   // Shift amount from the low bits of the second operand
   assign shamt = op2[4:0];

   assign shl   = op1 << shamt;
   assign shr_l = op1 >> shamt;
   assign shr_a = $signed(op1) >>> shamt;

   always_comb begin
      case (alu_op)
         // Add and subtract come from the shared adder
         ex_pkg::ALU_ADD,
         ex_pkg::ALU_SUB: begin
            result = sum;
         end
         ex_pkg::ALU_AND: begin
            result = op1 & op2;
         end
         ex_pkg::ALU_OR: begin
            result = op1 | op2;
         end
         ex_pkg::ALU_XOR: begin
            result = op1 ^ op2;
         end
         ex_pkg::ALU_SLL: begin
            result = shl;
         end
         ex_pkg::ALU_SRL: begin
            result = shr_l;
         end
         ex_pkg::ALU_SRA: begin
            result = shr_a;
         end
         default: begin
            result = sum;
         end
      endcase
   end

endmodule

/* logic/ex_bru.sv */
// Branch condition, target, link value and prediction check
module ex_bru (
   input  ex_pkg::bru_op_e           bru_op,
   input  logic [ex_pkg::PC_W-1:0]   pc,
   input  logic [ex_pkg::PC_W-1:0]   npc,
   input  logic [ex_pkg::XLEN-1:0]   imm,
   input  logic [ex_pkg::XLEN-1:0]   op1,
   input  logic [ex_pkg::XLEN-1:0]   sum,
   input  logic                      carry,
   input  logic                      overflow,
   input  logic                      pred_taken,
   input  logic [ex_pkg::PC_W-1:0]   pred_tgt,
   output logic                      taken,
   output logic [ex_pkg::PC_W-1:0]   tgt,
   output logic [ex_pkg::XLEN-1:0]   link,
   output logic                      mispred
);

   logic                    is_eq;
   logic                    is_lt;
   logic                    is_ltu;
   logic [ex_pkg::PC_W-1:0] pc_rel;

   // Flags of op1 - op2 from the shared adder
   assign is_eq  = (sum == '0);
   assign is_lt  = sum[ex_pkg::XLEN-1] ^ overflow;
   // No carry out means a borrow, so op1 is below op2
   assign is_ltu = ~carry;

   always_comb begin
      case (bru_op)
         ex_pkg::BRU_BEQ:  taken = is_eq;
         ex_pkg::BRU_BNE:  taken = ~is_eq;
         ex_pkg::BRU_BLT:  taken = is_lt;
         ex_pkg::BRU_BGE:  taken = ~is_lt;
         ex_pkg::BRU_BLTU: taken = is_ltu;
         ex_pkg::BRU_BGEU: taken = ~is_ltu;
         ex_pkg::BRU_JREL,
         ex_pkg::BRU_JREG: taken = 1'b1;
         default:          taken = 1'b0;
      endcase
   end

   // Word offset added to the word PC
   assign pc_rel = pc + imm[ex_pkg::PC_W-1:0];

   // Register jumps take the word part of op1 + imm from the adder
   assign tgt = (bru_op == ex_pkg::BRU_JREG) ? sum[ex_pkg::XLEN-1:ex_pkg::XLEN-ex_pkg::PC_W]
                                               : pc_rel;

   // Return address as a byte address
   assign link = {npc, 2'b00};

   // Target only matters when the branch is taken
   assign mispred = (taken ^ pred_taken) | (taken & (tgt != pred_tgt));

endmodule

/* logic/ex_pipe.sv */
// Execution pipe top with shared adder, unit instances, result mux, fault merge and stage registers
module ex_pipe (
   input  logic            clk,
   input  logic            rst_n,
   input  logic            flush,
   input  logic            req_valid,
   input  ex_pkg::ex_req_t req,
   output logic            req_ready,
   input  logic            wb_ready,
   output logic            wb_valid,
   output ex_pkg::ex_wb_t  wb
);

   logic                      is_alu;
   logic                      is_bru;
   logic                      is_mem;
   logic                      is_cmp;
   logic                      use_imm;
   logic                      add_sub;
   logic [ex_pkg::XLEN-1:0]   add_opb;
   logic [ex_pkg::XLEN-1:0]   add_b;
   logic [ex_pkg::XLEN-1:0]   add_sum;
   logic                      add_carry;
   logic                      add_overflow;
   logic [ex_pkg::PC_W-1:0]   npc;
   logic [ex_pkg::XLEN-1:0]   alu_result;
   logic                      b_taken;
   logic [ex_pkg::PC_W-1:0]   b_tgt;
   logic [ex_pkg::XLEN-1:0]   b_link;
   logic                      b_mispred;
   logic [ex_pkg::XLEN-1:0]   agu_addr;
   logic                      agu_misalign;
   logic [ex_pkg::FE_W-1:0]   flt_code;
   logic                      s1i_exc;
   logic                      s1i_prd_we;
   logic                      load;
   // Stage registers
   logic [ex_pkg::ROB_AW-1:0] s1o_rob_id;
   logic [ex_pkg::PRF_AW-1:0] s1o_prd;
   logic                      s1o_prd_we;
   logic [ex_pkg::XLEN-1:0]   s1o_wdata;
   logic                      s1o_fls;
   logic [ex_pkg::PC_W-1:0]   s1o_fls_tgt;
   logic                      s1o_exc;
   logic [ex_pkg::XLEN-1:0]   s1o_opera;
   logic [ex_pkg::XLEN-1:0]   s1o_operb;

   assign is_alu = (req.fu == ex_pkg::FU_ALU);
   assign is_bru = (req.fu == ex_pkg::FU_BRU);
   assign is_mem = (req.fu == ex_pkg::FU_LSU) | (req.fu == ex_pkg::FU_EPU);

   // Conditional branches compare through the adder
   assign is_cmp = is_bru & (req.bru_op != ex_pkg::BRU_JREL) & (req.bru_op != ex_pkg::BRU_JREG);

   assign use_imm = is_mem | (is_bru & (req.bru_op == ex_pkg::BRU_JREG));
   assign add_sub = (is_alu & (req.alu_op == ex_pkg::ALU_SUB)) | is_cmp;

   // Shared adder subtracts as op1 + ~b + 1
   assign add_opb = use_imm ? req.imm : req.op2;
   assign add_b   = add_sub ? ~add_opb : add_opb;
   assign {add_carry, add_sum} = {1'b0, req.op1} + {1'b0, add_b} + {{ex_pkg::XLEN{1'b0}}, add_sub};
   assign add_overflow = (req.op1[ex_pkg::XLEN-1] == add_b[ex_pkg::XLEN-1]) &
                         (add_sum[ex_pkg::XLEN-1] != req.op1[ex_pkg::XLEN-1]);

   assign npc = req.pc + {{(ex_pkg::PC_W-1){1'b0}}, 1'b1};

   ex_alu u_alu (
      .alu_op (req.alu_op),
      .op1    (req.op1),
      .op2    (req.op2),
      .sum    (add_sum),
      .result (alu_result)
   );

   ex_bru u_bru (
      .bru_op     (req.bru_op),
      .pc         (req.pc),
      .npc        (npc),
      .imm        (req.imm),
      .op1        (req.op1),
      .sum        (add_sum),
      .carry      (add_carry),
      .overflow   (add_overflow),
      .pred_taken (req.pred_taken),
      .pred_tgt   (req.pred_tgt),
      .taken      (b_taken),
      .tgt        (b_tgt),
      .link       (b_link),
      .mispred    (b_mispred)
   );

   ex_agu u_agu (
      .mem_sz   (req.mem_sz),
      .sum      (add_sum),
      .addr     (agu_addr),
      .misalign (agu_misalign)
   );

   ex_stage_buf u_buf (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .in_valid  (req_valid),
      .out_ready (wb_ready),
      .in_ready  (req_ready),
      .out_valid (wb_valid),
      .load      (load)
   );

   // Front-end fault wins over the alignment fault
   assign s1i_exc  = (|req.fe) | (is_mem & agu_misalign);
   assign flt_code = (|req.fe) ? req.fe : ex_pkg::FLT_MISALIGN;

   // Memory and system ops write back at commit, not here
   assign s1i_prd_we = (is_alu | is_bru) & req.prd_we & ~s1i_exc;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         s1o_prd_we <= 1'b0;
         s1o_fls    <= 1'b0;
         s1o_exc    <= 1'b0;
      end else if (flush) begin
         s1o_prd_we <= 1'b0;
      end else if (load) begin
         s1o_prd_we <= s1i_prd_we;
         s1o_fls    <= is_bru & b_mispred;
         s1o_exc    <= s1i_exc;
      end
   end

   always_ff @(posedge clk) begin
      if (load) begin
         s1o_rob_id  <= req.rob_id;
         s1o_prd     <= req.prd;
         s1o_wdata   <= is_bru ? b_link : alu_result;
         s1o_fls_tgt <= (is_bru & b_taken) ? b_tgt : npc;
         s1o_opera   <= s1i_exc ? {{(ex_pkg::XLEN-ex_pkg::FE_W){1'b0}}, flt_code} : agu_addr;
         s1o_operb   <= req.op2;
      end
   end

   always_comb begin
      wb.rob_id  = s1o_rob_id;
      wb.prd     = s1o_prd;
      wb.prd_we  = s1o_prd_we & wb_valid;
      wb.wdata   = s1o_wdata;
      wb.fls     = s1o_fls;
      wb.fls_tgt = s1o_fls_tgt;
      wb.exc     = s1o_exc;
      wb.opera   = s1o_opera;
      wb.operb   = s1o_operb;
   end

endmodule

/* logic/ex_pkg.sv */
// Execution pipe widths, opcode enums, fault codes, issue request and writeback record types
package ex_pkg;

   // Datapath and index widths
   localparam int XLEN   = 32;
   localparam int PC_W   = 30;
   localparam int PRF_AW = 6;
   localparam int ROB_AW = 4;
   localparam int FE_W   = 3;

   // Fault code for an unaligned load/store/system address
   localparam logic [FE_W-1:0] FLT_MISALIGN = 3'd5;

   typedef enum logic [1:0] {
      FU_ALU,
      FU_BRU,
      FU_LSU,
      FU_EPU
   } fu_e;

   typedef enum logic [2:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA
   } alu_op_e;

   typedef enum logic [3:0] {
      BRU_BEQ  = 4'd0,
      BRU_BNE  = 4'd1,
      BRU_BLT  = 4'd2,
      BRU_BGE  = 4'd3,
      BRU_BLTU = 4'd4,
      BRU_BGEU = 4'd5,
      BRU_JREL = 4'd6,
      BRU_JREG = 4'd7
   } bru_op_e;

   typedef enum logic [1:0] {
      MEM_B,
      MEM_H,
      MEM_W
   } mem_sz_e;

   // Issued micro-op from the reservation station
   typedef struct packed {
      fu_e               fu;
      alu_op_e           alu_op;
      bru_op_e           bru_op;
      mem_sz_e           mem_sz;
      logic [FE_W-1:0]   fe;
      logic              pred_taken;
      logic [PC_W-1:0]   pred_tgt;
      logic [PC_W-1:0]   pc;
      logic [XLEN-1:0]   imm;
      logic [XLEN-1:0]   op1;
      logic [XLEN-1:0]   op2;
      logic [PRF_AW-1:0] prd;
      logic              prd_we;
      logic [ROB_AW-1:0] rob_id;
   } ex_req_t;

   // Result toward writeback and the ROB
   typedef struct packed {
      logic [ROB_AW-1:0] rob_id;
      logic [PRF_AW-1:0] prd;
      logic              prd_we;
      logic [XLEN-1:0]   wdata;
      logic              fls;
      logic [PC_W-1:0]   fls_tgt;
      logic              exc;
      logic [XLEN-1:0]   opera;
      logic [XLEN-1:0]   operb;
   } ex_wb_t;

endpackage

/* logic/ex_stage_buf.sv */
// Valid/ready control of the single execution stage register with flush
module ex_stage_buf (
   input  logic clk,
   input  logic rst_n,
   input  logic flush,
   input  logic in_valid,
   input  logic out_ready,
   output logic in_ready,
   output logic out_valid,
   output logic load
);

   logic full;

   // Room when empty or when the held item leaves this cycle
   assign in_ready = (~full | out_ready) & ~flush;

   assign load = in_valid & in_ready;

   assign out_valid = full;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         full <= 1'b0;
      end else if (flush) begin
         full <= 1'b0;
      end else if (load) begin
         full <= 1'b1;
      end else if (out_ready) begin
         // Consumed with nothing new behind it
         full <= 1'b0;
      end
   end

endmodule

/* tb/tb_ex_pipe.sv */
// Testbench for the execution pipe with reference model, directed tests, scoreboard and watchdog
module tb_ex_pipe;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int          CLK_PERIOD = 8;
   localparam int          N_REQ      = 128;
   localparam logic [31:0] SEED       = 32'h9e33_cdc3;

   logic            clk;
   logic            rst_n;
   logic            flush;
   logic            req_valid;
   ex_pkg::ex_req_t req;
   logic            req_ready;
   logic            wb_ready;
   logic            wb_valid;
   ex_pkg::ex_wb_t  wb;

   // Scoreboard state
   ex_pkg::ex_req_t exp_q[$];
   string           cur_test;
   logic            acc_prev;
   logic            hold_prev;
   ex_pkg::ex_wb_t  held_wb;

   ex_pipe u_ex_pipe (
      .clk       (clk),
      .rst_n     (rst_n),
      .flush     (flush),
      .req_valid (req_valid),
      .req       (req),
      .req_ready (req_ready),
      .wb_ready  (wb_ready),
      .wb_valid  (wb_valid),
      .wb        (wb)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   task automatic check(input string what, input logic [159:0] exp, input logic [159:0] act);
      if (exp !== act) begin
         $display("FAIL %s %s: expected %0h, actual %0h", cur_test, what, exp, act);
         $display("Errors found");
         $fatal(1, "stopping at the first mismatch");
      end
   endtask

   // Taken flag in the top bit, word target below it
   function automatic logic [30:0] branch_ref(input ex_pkg::ex_req_t r);
      logic        taken;
      logic [31:0] jaddr;
      logic [29:0] tgt;
      case (r.bru_op)
         ex_pkg::BRU_BEQ:  taken = (r.op1 == r.op2);
         ex_pkg::BRU_BNE:  taken = (r.op1 != r.op2);
         ex_pkg::BRU_BLT:  taken = ($signed(r.op1) < $signed(r.op2));
         ex_pkg::BRU_BGE:  taken = ($signed(r.op1) >= $signed(r.op2));
         ex_pkg::BRU_BLTU: taken = (r.op1 < r.op2);
         ex_pkg::BRU_BGEU: taken = (r.op1 >= r.op2);
         ex_pkg::BRU_JREL,
         ex_pkg::BRU_JREG: taken = 1'b1;
         default:          taken = 1'b0;
      endcase
      jaddr = r.op1 + r.imm;
      tgt = (r.bru_op == ex_pkg::BRU_JREG) ? jaddr[31:2] : r.pc + r.imm[29:0];
      return {taken, tgt};
   endfunction

   function automatic ex_pkg::ex_wb_t model(input ex_pkg::ex_req_t r);
      ex_pkg::ex_wb_t w;
      logic [30:0]    bo;
      logic [29:0]    npc;
      logic [31:0]    addr;
      logic           is_mem;
      logic           mis;
      logic           misalign;
      w = '0;
      npc = r.pc + 30'd1;
      addr = r.op1 + r.imm;
      is_mem = (r.fu == ex_pkg::FU_LSU) || (r.fu == ex_pkg::FU_EPU);
      case (r.alu_op)
         ex_pkg::ALU_ADD: w.wdata = r.op1 + r.op2;
         ex_pkg::ALU_SUB: w.wdata = r.op1 - r.op2;
         ex_pkg::ALU_AND: w.wdata = r.op1 & r.op2;
         ex_pkg::ALU_OR:  w.wdata = r.op1 | r.op2;
         ex_pkg::ALU_XOR: w.wdata = r.op1 ^ r.op2;
         ex_pkg::ALU_SLL: w.wdata = r.op1 << r.op2[4:0];
         ex_pkg::ALU_SRL: w.wdata = r.op1 >> r.op2[4:0];
         default:         w.wdata = $signed(r.op1) >>> r.op2[4:0];
      endcase
      bo = branch_ref(r);
      mis = (bo[30] != r.pred_taken) || (bo[30] && (bo[29:0] != r.pred_tgt));
      if (r.fu == ex_pkg::FU_BRU) begin
         w.wdata   = {npc, 2'b00};
         w.fls     = mis;
         w.fls_tgt = bo[30] ? bo[29:0] : npc;
      end
      case (r.mem_sz)
         ex_pkg::MEM_H: misalign = addr[0];
         ex_pkg::MEM_W: misalign = |addr[1:0];
         default:       misalign = 1'b0;
      endcase
      w.exc = (r.fe != '0) || (is_mem && misalign);
      if (r.fe != '0)
         w.opera = 32'(r.fe);
      else if (w.exc)
         w.opera = 32'(ex_pkg::FLT_MISALIGN);
      else
         w.opera = addr;
      w.operb  = r.op2;
      w.rob_id = r.rob_id;
      w.prd    = r.prd;
      w.prd_we = !is_mem && r.prd_we && !w.exc;
      return w;
   endfunction

   task automatic compare_wb(input ex_pkg::ex_req_t r, input ex_pkg::ex_wb_t act);
      ex_pkg::ex_wb_t e;
      logic           is_mem;
      e = model(r);
      is_mem = (r.fu == ex_pkg::FU_LSU) || (r.fu == ex_pkg::FU_EPU);
      check("rob_id", e.rob_id, act.rob_id);
      check("prd", e.prd, act.prd);
      check("prd_we", e.prd_we, act.prd_we);
      check("exc", e.exc, act.exc);
      check("fls", e.fls, act.fls);
      if (!is_mem)
         check("wdata", e.wdata, act.wdata);
      if (r.fu == ex_pkg::FU_BRU)
         check("fls_tgt", e.fls_tgt, act.fls_tgt);
      if (is_mem || e.exc)
         check("opera", e.opera, act.opera);
      if (is_mem)
         check("operb", e.operb, act.operb);
   endtask

   // Handshakes are sampled mid-cycle where all signals are settled
   always @(negedge clk) begin
      if (rst_n) begin
         if (acc_prev)
            check("wb_valid one cycle after accept", 1'b1, wb_valid);
         if (hold_prev) begin
            check("wb_valid held", 1'b1, wb_valid);
            check("wb held", held_wb, wb);
         end
         if (flush) begin
            exp_q.delete();
         end else if (wb_valid && wb_ready) begin
            if (exp_q.size() == 0) begin
               $display("A writeback came out with no request in flight");
               $display("Errors found");
               $fatal(1, "unexpected writeback");
            end
            compare_wb(exp_q.pop_front(), wb);
         end
         acc_prev = req_valid && req_ready;
         if (acc_prev)
            exp_q.push_back(req);
         hold_prev = wb_valid && !wb_ready && !flush;
         held_wb = wb;
      end
   end

   function automatic ex_pkg::ex_req_t rand_req(input ex_pkg::fu_e fu);
      ex_pkg::ex_req_t r;
      r = '0;
      r.fu         = fu;
      r.alu_op     = ex_pkg::alu_op_e'(3'($urandom_range(7)));
      r.bru_op     = ex_pkg::BRU_BEQ;
      r.mem_sz     = ex_pkg::MEM_W;
      r.pred_taken = 1'($urandom);
      r.pred_tgt   = 30'($urandom);
      r.pc         = 30'($urandom);
      r.imm        = $urandom;
      r.op1        = $urandom;
      r.op2        = $urandom;
      r.prd        = 6'($urandom);
      r.prd_we     = 1'($urandom);
      r.rob_id     = 4'($urandom);
      return r;
   endfunction

   // Called 1 ns after a rising edge, returns 1 ns after the accepting edge
   task automatic send(input ex_pkg::ex_req_t r);
      req = r;
      req_valid = 1'b1;
      @(negedge clk);
      while (!req_ready)
         @(negedge clk);
      @(posedge clk);
      #1;
      req_valid = 1'b0;
   endtask

   task automatic end_test();
      @(posedge clk);
      while (exp_q.size() != 0)
         @(posedge clk);
      #1;
   endtask

   task automatic alu_random();
      cur_test = "alu";
      repeat (40)
         send(rand_req(ex_pkg::FU_ALU));
      end_test();
   endtask

   task automatic branch_resolve();
      ex_pkg::ex_req_t r;
      logic [30:0]     bo;
      cur_test = "bru";
      for (int op = 0; op < 8; op++) begin
         for (int c = 0; c < 3; c++) begin
            for (int p = 0; p < 2; p++) begin
               r = rand_req(ex_pkg::FU_BRU);
               r.bru_op = ex_pkg::bru_op_e'(4'(op));
               // Equal, signed-less and unsigned-less operand pairs
               if (c == 0) begin
                  r.op2 = r.op1;
               end else if (c == 1) begin
                  r.op1 |= 32'h8000_0000;
                  r.op2 &= 32'h7fff_ffff;
               end else begin
                  r.op1 &= 32'h7fff_ffff;
                  r.op2 |= 32'h8000_0000;
               end
               bo = branch_ref(r);
               r.pred_taken = bo[30];
               r.pred_tgt   = bo[29:0];
               if (p == 1 && c == 1)
                  r.pred_taken = ~bo[30];
               else if (p == 1)
                  r.pred_tgt = bo[29:0] + 30'd1;
               send(r);
            end
         end
      end
      end_test();
   endtask

   task automatic mem_address();
      ex_pkg::ex_req_t r;
      cur_test = "mem";
      for (int f = 0; f < 2; f++) begin
         for (int sz = 0; sz < 3; sz++) begin
            for (int off = 0; off < 4; off++) begin
               r = rand_req((f == 0) ? ex_pkg::FU_LSU : ex_pkg::FU_EPU);
               r.mem_sz = ex_pkg::mem_sz_e'(2'(sz));
               r.prd_we = 1'b1;
               r.op1    = {r.op1[31:2], 2'b00};
               r.imm    = {r.imm[31:2], 2'(off)};
               send(r);
            end
         end
      end
      end_test();
   endtask

   task automatic fault_inject();
      ex_pkg::ex_req_t r;
      cur_test = "front_end_fault";
      for (int f = 0; f < 4; f++) begin
         repeat (2) begin
            r = rand_req(ex_pkg::fu_e'(2'(f)));
            r.fe     = 3'($urandom_range(1, 7));
            r.prd_we = 1'b1;
            send(r);
         end
      end
      end_test();
   endtask

   task automatic stall_release();
      ex_pkg::ex_req_t r;
      cur_test = "backpressure";
      wb_ready = 1'b0;
      send(rand_req(ex_pkg::FU_ALU));
      r = rand_req(ex_pkg::FU_ALU);
      fork
         send(r);
         begin
            repeat (5) begin
               @(negedge clk);
               check("req_ready while stalled", 1'b0, req_ready);
            end
            @(posedge clk);
            #1;
            wb_ready = 1'b1;
         end
      join
      repeat (4)
         send(rand_req(ex_pkg::FU_ALU));
      end_test();
   endtask

   task automatic flush_stage();
      cur_test = "flush";
      wb_ready = 1'b0;
      send(rand_req(ex_pkg::FU_ALU));
      flush = 1'b1;
      @(posedge clk);
      #1;
      flush = 1'b0;
      @(negedge clk);
      check("wb_valid after flush", 1'b0, wb_valid);
      @(posedge clk);
      #1;
      wb_ready = 1'b1;
      send(rand_req(ex_pkg::FU_BRU));
      end_test();
   endtask

   // Each request gets 20 cycles on top of the reset time
   initial begin
      #((N_REQ * 20 + 10) * CLK_PERIOD);
      $display("Timeout: the tests did not finish within the time limit");
      $display("Errors found");
      $fatal(1, "watchdog expired");
   end

   initial begin
      void'($urandom(SEED));
      clk       = 1'b0;
      rst_n     = 1'b0;
      flush     = 1'b0;
      req_valid = 1'b0;
      req       = '0;
      wb_ready  = 1'b1;
      cur_test  = "reset";
      acc_prev  = 1'b0;
      hold_prev = 1'b0;
      held_wb   = '0;
      repeat (10) @(posedge clk);
      #1;
      rst_n = 1'b1;
      @(negedge clk);
      check("req_ready", 1'b1, req_ready);
      check("wb_valid", 1'b0, wb_valid);
      check("wb.prd_we", 1'b0, wb.prd_we);
      check("wb.fls", 1'b0, wb.fls);
      check("wb.exc", 1'b0, wb.exc);
      @(posedge clk);
      #1;
      alu_random();
      branch_resolve();
      mem_address();
      fault_inject();
      stall_release();
      flush_stage();
      $display("No errors");
      $finish;
   end

endmodule
